// File: hw/mc_cfg_pkg.sv
package mc_cfg_pkg;

    // ==============================
    // Cluster topology
    // ==============================

    // Cores attached to the hub
    localparam int NUM_CORES = 4;

    // Bits needed to name one core
    localparam int CORE_ID_W = $clog2(NUM_CORES);

    // Index of a single core
    typedef logic [CORE_ID_W-1:0] core_id_t;

    // One bit per core, core 0 in bit 0
    typedef logic [NUM_CORES-1:0] core_mask_t;

endpackage : mc_cfg_pkg

// File: hw/mc_msg_pkg.sv
package mc_msg_pkg;

    // ==============================
    // Message payload
    // ==============================

    // Width of one message word
    localparam int MSG_W = 32;

    typedef logic [MSG_W-1:0] msg_t;

    // ==============================
    // Hardware barriers
    // ==============================

    // Barriers available to software
    localparam int NUM_BARRIERS = 4;

    // Bits needed to select a barrier
    localparam int BARRIER_ID_W = $clog2(NUM_BARRIERS);

    typedef logic [BARRIER_ID_W-1:0] barrier_id_t;

endpackage : mc_msg_pkg

// File: hw/inter_core_comm_if.sv
`timescale 1ns/1ps

interface inter_core_comm_if
    import mc_cfg_pkg::*;
    import mc_msg_pkg::*;
();

    // ==============================
    // Send side, one slot per core
    // ==============================

    // Core offers a word
    core_mask_t                   send_valid;
    // Target core of each offered word
    core_id_t [NUM_CORES-1:0]     send_dest;
    core_id_t [NUM_CORES-1:0]     recv_source;
    msg_t     [NUM_CORES-1:0]     send_message;
    // Hub takes the word this cycle
    core_mask_t                   send_ready;

    // ==============================
    // Receive side, one slot per core
    // ==============================

    core_mask_t                   recv_valid;
    msg_t     [NUM_CORES-1:0]     recv_message;
    // Must not look at recv_valid
    core_mask_t                   recv_ready;

    // Core end of the channels
    modport core (
        output send_valid, send_dest, send_message, recv_ready,
        input  send_ready, recv_valid, recv_source, recv_message
    );

    // Hub end of the channels
    modport manager (
        input  send_valid, send_dest, send_message, recv_ready,
        output send_ready, recv_valid, recv_source, recv_message
    );

endinterface : inter_core_comm_if

// File: hw/sync_primitives_if.sv
`timescale 1ns/1ps

interface sync_primitives_if
    import mc_cfg_pkg::*;
    import mc_msg_pkg::*;
();

    // ==============================
    // Barrier arrival
    // ==============================

    core_mask_t                     arrive_valid;
    // Barrier each core is arriving at
    barrier_id_t [NUM_CORES-1:0]    barrier_id;
    core_mask_t                     arrive_ready;

    // ==============================
    // Barrier release
    // ==============================

    // Hub tells the core its barrier is complete
    core_mask_t                     release_valid;
    // Core acknowledges the release
    core_mask_t                     release_ready;

    modport core (
        output arrive_valid, barrier_id, release_ready,
        input  arrive_ready, release_valid
    );

    modport manager (
        input  arrive_valid, barrier_id, release_ready,
        output arrive_ready, release_valid
    );

endinterface : sync_primitives_if

// File: hw/msg_arbiter.sv
`timescale 1ns/1ps

module msg_arbiter
    import mc_cfg_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    // One request bit per sending core
    input  core_mask_t requests,
    // Router saw the grant complete
    input  logic       transfer_done,
    output logic       grant_valid,
    output core_id_t   grant_id
);

    // Core with the highest priority this cycle
    core_id_t ptr_q;
    // Slot right after the current winner
    core_id_t ptr_next;

    // ==============================
    // Rotating search
    // ==============================

    // Walk from the pointer and wrap, first request wins
    always_comb begin : rr_search
        core_id_t idx;
        grant_valid = 1'b0;
        grant_id    = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            idx = core_id_t'((int'(ptr_q) + i) % NUM_CORES);
            if (!grant_valid && requests[idx]) begin
                grant_valid = 1'b1;
                grant_id    = idx;
            end
        end
    end

    assign ptr_next = core_id_t'((int'(grant_id) + 1) % NUM_CORES);

    // ==============================
    // Pointer register
    // ==============================

    // Moves only on a real transfer
    // A winner stalled by its destination keeps priority
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (transfer_done) begin
            ptr_q <= ptr_next;
        end
    end

endmodule : msg_arbiter

// File: hw/msg_router.sv
`timescale 1ns/1ps

module msg_router
    import mc_cfg_pkg::*;
    import mc_msg_pkg::*;
(
    input  logic                      grant_valid,
    input  core_id_t                  grant_id,
    // Back to the arbiter, pointer advance
    output logic                      transfer_done,
    inter_core_comm_if.manager        comm
);

    // Destination named by the granted source
    core_id_t dest_id;
    logic     dest_ready;
    // Word held by the granted source
    msg_t     grant_message;

    assign dest_id       = comm.send_dest[grant_id];
    assign dest_ready    = comm.recv_ready[dest_id];
    assign grant_message = comm.send_message[grant_id];

    // Nothing moves while the winner's target is busy
    assign transfer_done = grant_valid & dest_ready;

    // ==============================
    // Steering
    // ==============================

    always_comb begin : steer
        // All channels idle by default
        comm.send_ready   = '0;
        comm.recv_valid   = '0;
        comm.recv_source  = '0;
        comm.recv_message = '0;

        if (transfer_done) begin
            // Source sees its handshake
            comm.send_ready[grant_id] = 1'b1;
            // Destination sees the word in the same cycle
            comm.recv_valid[dest_id]   = 1'b1;
            comm.recv_source[dest_id]  = grant_id;
            comm.recv_message[dest_id] = grant_message;
        end
    end

endmodule : msg_router

// File: hw/barrier_sync.sv
`timescale 1ns/1ps

module barrier_sync
    import mc_cfg_pkg::*;
    import mc_msg_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    sync_primitives_if.manager sync
);

    // ==============================
    // Barrier state
    // ==============================

    // Cores that have arrived, per barrier
    core_mask_t [NUM_BARRIERS-1:0] arrival_q;
    core_mask_t [NUM_BARRIERS-1:0] arrival_d;
    // Cores that acknowledged release, per barrier
    core_mask_t [NUM_BARRIERS-1:0] release_q;
    core_mask_t [NUM_BARRIERS-1:0] release_d;

    // Every core arrived
    logic [NUM_BARRIERS-1:0] full;
    // Every core acknowledged
    logic [NUM_BARRIERS-1:0] all_released;

    always_comb begin : barrier_status
        for (int b = 0; b < NUM_BARRIERS; b++) begin
            full[b]         = &arrival_q[b];
            all_released[b] = &release_q[b];
        end
    end

    // ==============================
    // Arrivals
    // ==============================

    always_comb begin : arrive_accept
        barrier_id_t bid;
        sync.arrive_ready = '0;
        arrival_d         = arrival_q;

        for (int c = 0; c < NUM_CORES; c++) begin
            bid = sync.barrier_id[c];
            // Refuse repeats and refuse while the barrier is busy releasing
            if (sync.arrive_valid[c] && !arrival_q[bid][c] && !full[bid]) begin
                sync.arrive_ready[c] = 1'b1;
                arrival_d[bid][c]    = 1'b1;
            end
        end

        // Round finished, open the barrier for the next one
        for (int b = 0; b < NUM_BARRIERS; b++) begin
            if (full[b] && all_released[b]) begin
                arrival_d[b] = '0;
            end
        end
    end

    // ==============================
    // Releases
    // ==============================

    always_comb begin : release_drive
        core_mask_t pending;
        sync.release_valid = '0;
        release_d          = release_q;

        for (int b = 0; b < NUM_BARRIERS; b++) begin
            // Arrived cores still waiting for their release
            pending = (full[b] && !all_released[b]) ? (arrival_q[b] & ~release_q[b]) : '0;
            sync.release_valid = sync.release_valid | pending;
            // Record acks, each core drops out the cycle after
            release_d[b] = release_q[b] | (pending & sync.release_ready);
            if (full[b] && all_released[b]) begin
                release_d[b] = '0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arrival_q <= '0;
            release_q <= '0;
        end else begin
            arrival_q <= arrival_d;
            release_q <= release_d;
        end
    end

endmodule : barrier_sync

// File: hw/core_manager.sv
`timescale 1ns/1ps

module core_manager
    import mc_cfg_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    // Cores that report themselves running
    input  core_mask_t         core_active,
    // Hub view of the running cores, one cycle later
    output core_mask_t         core_ready,
    inter_core_comm_if.manager comm,
    sync_primitives_if.manager sync
);

    // ==============================
    // Message path
    // ==============================

    // Arbiter to router
    logic     grant_valid;
    core_id_t grant_id;
    // Router back to arbiter
    logic     transfer_done;

    // Send requests compete directly
    msg_arbiter u_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .requests      (comm.send_valid),
        .transfer_done (transfer_done),
        .grant_valid   (grant_valid),
        .grant_id      (grant_id)
    );

    msg_router u_router (
        .grant_valid   (grant_valid),
        .grant_id      (grant_id),
        .transfer_done (transfer_done),
        .comm          (comm)
    );

    // ==============================
    // Barriers
    // ==============================

    barrier_sync u_barrier (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .sync   (sync)
    );

    // ==============================
    // Core status
    // ==============================

    // Ready trails active by one clock
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            core_ready <= '0;
        end else begin
            core_ready <= core_active;
        end
    end

endmodule : core_manager

// File: hw/mc_coord_top.sv
`timescale 1ns/1ps

module mc_coord_top
    import mc_cfg_pkg::*;
    import mc_msg_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               rst_ni,

    // Core status
    input  logic [NUM_CORES-1:0]               core_active,
    output logic [NUM_CORES-1:0]               core_ready,

    // Send channels, core 0 in the low bits
    input  logic [NUM_CORES-1:0]               send_valid,
    input  logic [NUM_CORES*CORE_ID_W-1:0]     send_dest_flat,
    input  logic [NUM_CORES*MSG_W-1:0]         send_message_flat,
    output logic [NUM_CORES-1:0]               send_ready,

    // Receive channels
    output logic [NUM_CORES-1:0]               recv_valid,
    output logic [NUM_CORES*CORE_ID_W-1:0]     recv_source_flat,
    output logic [NUM_CORES*MSG_W-1:0]         recv_message_flat,
    input  logic [NUM_CORES-1:0]               recv_ready,

    // Barrier arrival
    input  logic [NUM_CORES-1:0]               arrive_valid,
    input  logic [NUM_CORES*BARRIER_ID_W-1:0]  barrier_id_flat,
    output logic [NUM_CORES-1:0]               arrive_ready,

    // Barrier release
    output logic [NUM_CORES-1:0]               release_valid,
    input  logic [NUM_CORES-1:0]               release_ready
);

    // ==============================
    // Interface instances
    // ==============================

    inter_core_comm_if comm ();
    sync_primitives_if sync ();

    // ==============================
    // Pins into the bundles
    // ==============================

    // Packed arrays keep core 0 in the low slice
    assign comm.send_valid   = send_valid;
    assign comm.send_dest    = send_dest_flat;
    assign comm.send_message = send_message_flat;
    assign comm.recv_ready   = recv_ready;

    assign sync.arrive_valid  = arrive_valid;
    assign sync.barrier_id    = barrier_id_flat;
    assign sync.release_ready = release_ready;

    // ==============================
    // Bundles back out to pins
    // ==============================

    assign send_ready        = comm.send_ready;
    assign recv_valid        = comm.recv_valid;
    assign recv_source_flat  = comm.recv_source;
    assign recv_message_flat = comm.recv_message;

    assign arrive_ready  = sync.arrive_ready;
    assign release_valid = sync.release_valid;

    // Coordination hub
    core_manager u_manager (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .core_active (core_active),
        .core_ready  (core_ready),
        .comm        (comm),
        .sync        (sync)
    );

endmodule : mc_coord_top

// File: verif/mc_coord_tb.sv
`timescale 1ns/1ps

module mc_coord_tb
    import mc_cfg_pkg::*;
    import mc_msg_pkg::*;
();

    // Expected values of every combinational output
    typedef struct packed {
        core_mask_t                          send_ready;
        core_mask_t                          recv_valid;
        logic [NUM_CORES*CORE_ID_W-1:0]      recv_source;
        logic [NUM_CORES*MSG_W-1:0]          recv_message;
        core_mask_t                          arrive_ready;
        core_mask_t                          release_valid;
    } expect_t;

    logic                               clk_i = 1'b0;
    logic                               rst_ni;
    core_mask_t                         core_active;
    core_mask_t                         core_ready;
    core_mask_t                         send_valid;
    core_mask_t                         send_ready;
    core_mask_t                         recv_valid;
    core_mask_t                         recv_ready;
    core_mask_t                         arrive_valid;
    core_mask_t                         arrive_ready;
    core_mask_t                         release_valid;
    core_mask_t                         release_ready;
    logic [NUM_CORES*CORE_ID_W-1:0]     send_dest_flat;
    logic [NUM_CORES*CORE_ID_W-1:0]     recv_source_flat;
    logic [NUM_CORES*MSG_W-1:0]         send_message_flat;
    logic [NUM_CORES*MSG_W-1:0]         recv_message_flat;
    logic [NUM_CORES*BARRIER_ID_W-1:0]  barrier_id_flat;

    // Model state, pointer plus arrival and release masks per barrier
    core_id_t                           m_ptr;
    logic [NUM_BARRIERS*NUM_CORES-1:0]  m_arr;
    logic [NUM_BARRIERS*NUM_CORES-1:0]  m_rel;
    core_mask_t                         m_ready;

    int     err_cnt = 0;
    int     timeout_cnt = 0;
    integer seed = 63;

    mc_coord_top UUT (.*);

    // 40 ns clock
    always #20 clk_i = ~clk_i;

    // ==============================
    // Reference model
    // ==============================

    function automatic expect_t ref_outputs(
        input core_mask_t sv, input logic [7:0] sd, input logic [127:0] sm,
        input core_mask_t rr, input core_mask_t av, input logic [7:0] bid,
        input core_id_t ptr, input logic [15:0] arr, input logic [15:0] rel);
        expect_t e;
        int      win;
        int      d;
        int      b;
        e   = '0;
        win = -1;
        // First requester at or after the pointer wins
        for (int i = 0; i < NUM_CORES; i++) begin
            if (win < 0 && sv[(int'(ptr) + i) % NUM_CORES]) win = (int'(ptr) + i) % NUM_CORES;
        end
        if (win >= 0) begin
            d = int'(sd[win*2 +: 2]);
            // Blocked winner stalls everyone
            if (rr[d]) begin
                e.send_ready[win]          = 1'b1;
                e.recv_valid[d]            = 1'b1;
                e.recv_source[d*2 +: 2]    = 2'(win);
                e.recv_message[d*32 +: 32] = sm[win*32 +: 32];
            end
        end
        for (int c = 0; c < NUM_CORES; c++) begin
            b = int'(bid[c*2 +: 2]);
            if (av[c] && !arr[b*4 + c] && arr[b*4 +: 4] != 4'hf) e.arrive_ready[c] = 1'b1;
        end
        // Full barrier releases the cores not yet acknowledged
        for (int bb = 0; bb < NUM_BARRIERS; bb++) begin
            if (arr[bb*4 +: 4] == 4'hf && rel[bb*4 +: 4] != 4'hf) begin
                e.release_valid = e.release_valid | ~rel[bb*4 +: 4];
            end
        end
        return e;
    endfunction

    task automatic check_field(input string name, input logic [127:0] exp_v,
                               input logic [127:0] got_v);
        assert (got_v === exp_v) else begin
            err_cnt++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, got_v);
        end
    endtask

    // ==============================
    // Compare process
    // ==============================

    always begin : compare_outputs
        expect_t                           e;
        logic [NUM_BARRIERS*NUM_CORES-1:0] na;
        logic [NUM_BARRIERS*NUM_CORES-1:0] nr;
        @(posedge clk_i);
        #5;
        if (!rst_ni) begin
            m_ptr   = '0;
            m_arr   = '0;
            m_rel   = '0;
            m_ready = '0;
        end
        e = ref_outputs(send_valid, send_dest_flat, send_message_flat, recv_ready,
                        arrive_valid, barrier_id_flat, m_ptr, m_arr, m_rel);
        check_field("send_ready", e.send_ready, send_ready);
        check_field("recv_valid", e.recv_valid, recv_valid);
        check_field("recv_source_flat", e.recv_source, recv_source_flat);
        check_field("recv_message_flat", e.recv_message, recv_message_flat);
        check_field("arrive_ready", e.arrive_ready, arrive_ready);
        check_field("release_valid", e.release_valid, release_valid);
        check_field("core_ready", m_ready, core_ready);
        // Next model state, as registered at the coming edge
        if (rst_ni) begin
            na = m_arr;
            nr = m_rel;
            for (int c = 0; c < NUM_CORES; c++) begin
                if (e.send_ready[c]) m_ptr = core_id_t'((c + 1) % NUM_CORES);
                if (e.arrive_ready[c]) na[int'(barrier_id_flat[c*2 +: 2])*4 + c] = 1'b1;
            end
            for (int b = 0; b < NUM_BARRIERS; b++) begin
                if (&m_arr[b*4 +: 4]) begin
                    nr[b*4 +: 4] = m_rel[b*4 +: 4] | release_ready;
                    if (&m_rel[b*4 +: 4]) begin
                        na[b*4 +: 4] = '0;
                        nr[b*4 +: 4] = '0;
                    end
                end
            end
            m_arr   = na;
            m_rel   = nr;
            m_ready = core_active;
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    // Sel 0 send_ready, 1 arrive_ready, 2 release_valid
    task automatic wait_bit(input int sel, input int idx, input logic level, input string what);
        logic v;
        for (int t = 0; t < 50; t++) begin
            #1;
            v = (sel == 0) ? send_ready[idx] : (sel == 1) ? arrive_ready[idx] : release_valid[idx];
            if (v == level) return;
            @(posedge clk_i);
        end
        timeout_cnt++;
        $display("Timeout at %0t: %s never happened for core %0d", $time, what, idx);
    endtask

    // One full round on a barrier, random arrival and ack order
    task automatic barrier_round(input int b);
        int order [NUM_CORES];
        int k;
        int tmp;
        for (int c = 0; c < NUM_CORES; c++) order[c] = c;
        for (int c = NUM_CORES - 1; c > 0; c--) begin
            k        = $unsigned($random(seed)) % (c + 1);
            tmp      = order[c];
            order[c] = order[k];
            order[k] = tmp;
        end
        for (int i = 0; i < NUM_CORES; i++) begin
            repeat (1 + $unsigned($random(seed)) % 4) @(posedge clk_i);
            barrier_id_flat[order[i]*BARRIER_ID_W +: BARRIER_ID_W] <= barrier_id_t'(b);
            arrive_valid[order[i]] <= 1'b1;
            wait_bit(1, order[i], 1'b1, "barrier arrival");
            assert (release_valid == '0) else begin
                err_cnt++;
                $display("[FAIL] %0t release_valid expected %b got %b", $time,
                         core_mask_t'(0), release_valid);
            end
            @(posedge clk_i);
            arrive_valid[order[i]] <= 1'b0;
            if (i == 0) begin
                // Same core tries again
                @(posedge clk_i);
                arrive_valid[order[0]] <= 1'b1;
                #1;
                assert (!arrive_ready[order[0]]) else begin
                    err_cnt++;
                    $display("[FAIL] %0t arrive_ready[%0d] expected 0 got %b", $time,
                             order[0], arrive_ready[order[0]]);
                end
                @(posedge clk_i);
                arrive_valid[order[0]] <= 1'b0;
            end
        end
        wait_bit(2, order[0], 1'b1, "barrier release");
        for (int i = NUM_CORES - 1; i >= 0; i--) begin
            repeat (1 + $unsigned($random(seed)) % 4) @(posedge clk_i);
            release_ready[order[i]] <= 1'b1;
            wait_bit(2, order[i], 1'b0, "release drop after ack");
            @(posedge clk_i);
            release_ready[order[i]] <= 1'b0;
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin : stimulus
        int         src;
        int         dst;
        int         w;
        int         hold;
        msg_t       word;
        int         nxt [NUM_CORES];
        int         rot [NUM_CORES];
        core_mask_t acc;
        core_mask_t exp_rr;
        bit         done;
        rst_ni            <= 1'b0;
        // All cores active through reset, ready has to stay low anyway
        core_active       <= '1;
        send_valid        <= '0;
        send_dest_flat    <= '0;
        send_message_flat <= '0;
        recv_ready        <= '0;
        arrive_valid      <= '0;
        barrier_id_flat   <= '0;
        release_ready     <= '0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Status under random activity
        repeat (20) begin
            @(posedge clk_i);
            core_active <= core_mask_t'($random(seed));
        end

        // Single delivery
        @(posedge clk_i);
        src  = $unsigned($random(seed)) % NUM_CORES;
        dst  = (src + 1 + $unsigned($random(seed)) % 3) % NUM_CORES;
        word = $random(seed);
        recv_ready <= '1;
        send_dest_flat[src*CORE_ID_W +: CORE_ID_W] <= core_id_t'(dst);
        send_message_flat[src*MSG_W +: MSG_W] <= word;
        send_valid[src] <= 1'b1;
        wait_bit(0, src, 1'b1, "single delivery");
        assert (recv_valid[dst] && recv_message_flat[dst*MSG_W +: MSG_W] == word) else begin
            err_cnt++;
            $display("[FAIL] %0t recv_message expected %h got %h", $time, word,
                     recv_message_flat[dst*MSG_W +: MSG_W]);
        end
        @(posedge clk_i);
        send_valid <= '0;

        // Round robin, everyone sends to its neighbour
        for (int c = 0; c < NUM_CORES; c++) begin
            send_dest_flat[c*CORE_ID_W +: CORE_ID_W] <= core_id_t'((c + 1) % NUM_CORES);
            send_message_flat[c*MSG_W +: MSG_W] <= msg_t'($random(seed));
        end
        send_valid <= '1;
        // Pointer names this cycle's winner, checks start one cycle later
        w = int'(m_ptr);
        repeat (12) begin
            @(posedge clk_i);
            #1;
            w      = (w + 1) % NUM_CORES;
            exp_rr = core_mask_t'(1) << w;
            assert (send_ready == exp_rr) else begin
                err_cnt++;
                $display("[FAIL] %0t send_ready expected %b got %b", $time, exp_rr, send_ready);
            end
        end

        // Back-pressure on the current winner
        @(posedge clk_i);
        send_valid <= '0;
        @(posedge clk_i);
        w    = int'(m_ptr);
        dst  = (w + 1) % NUM_CORES;
        hold = 1 + $unsigned($random(seed)) % 6;
        word = $random(seed);
        send_message_flat[w*MSG_W +: MSG_W] <= word;
        recv_ready <= ~(core_mask_t'(1) << dst);
        send_valid <= '1;
        repeat (hold) begin
            @(posedge clk_i);
            #1;
            assert (send_ready == '0) else begin
                err_cnt++;
                $display("[FAIL] %0t send_ready expected 0 got %b", $time, send_ready);
            end
        end
        @(posedge clk_i);
        recv_ready <= '1;
        wait_bit(0, w, 1'b1, "held message delivery");
        assert (recv_message_flat[dst*MSG_W +: MSG_W] == word) else begin
            err_cnt++;
            $display("[FAIL] %0t recv_message expected %h got %h", $time, word,
                     recv_message_flat[dst*MSG_W +: MSG_W]);
        end
        @(posedge clk_i);
        send_valid <= '0;

        // Two rounds on one barrier
        w = $unsigned($random(seed)) % NUM_BARRIERS;
        barrier_round(w);
        barrier_round(w);

        // Every core visits every barrier, rotated start
        for (int c = 0; c < NUM_CORES; c++) begin
            nxt[c] = 0;
            rot[c] = $unsigned($random(seed)) % NUM_BARRIERS;
        end
        acc  = '0;
        done = 1'b0;
        for (int t = 0; t < 400 && !done; t++) begin
            @(posedge clk_i);
            release_ready <= core_mask_t'($random(seed));
            for (int c = 0; c < NUM_CORES; c++) begin
                if (acc[c]) begin
                    arrive_valid[c] <= 1'b0;
                    nxt[c]++;
                end else if (!arrive_valid[c] && nxt[c] < NUM_BARRIERS && $random(seed) % 2) begin
                    barrier_id_flat[c*BARRIER_ID_W +: BARRIER_ID_W] <=
                        barrier_id_t'((nxt[c] + rot[c]) % NUM_BARRIERS);
                    arrive_valid[c] <= 1'b1;
                end
            end
            #1;
            acc  = arrive_valid & arrive_ready;
            done = (m_arr == '0) && (m_rel == '0);
            for (int c = 0; c < NUM_CORES; c++) if (nxt[c] < NUM_BARRIERS) done = 1'b0;
        end
        if (!done) begin
            timeout_cnt++;
            $display("Timeout at %0t: barriers did not all complete", $time);
        end
        @(posedge clk_i);
        release_ready <= '0;
        repeat (2) @(posedge clk_i);

        $display("Errors: %0d value mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : mc_coord_tb

// File: project.f
hw/mc_cfg_pkg.sv
hw/mc_msg_pkg.sv
hw/inter_core_comm_if.sv
hw/sync_primitives_if.sv
hw/msg_arbiter.sv
hw/msg_router.sv
hw/barrier_sync.sv
hw/core_manager.sv
hw/mc_coord_top.sv
verif/mc_coord_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the coordination hub testbench with Verilator and runs it.
# The run fails if the build fails, the simulator errors, or the log reports failure.

verilator --binary --timing -Wno-fatal -f project.f --top-module mc_coord_tb \
    -o mc_coord_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/mc_coord_sim > sim.log 2>&1 \
    || { echo "Simulator exited with an error, see sim.log"; exit 1; }

grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } \
    || { grep -q "sim passed" sim.log && echo "PASS" && exit 0 \
    || { echo "No result in sim.log"; exit 1; }; }
